// File: vlog.f
+incdir+include
hdl/hsi_pkg.sv
hdl/hsi_serializer.sv
hdl/hsi_deserializer.sv
hdl/hsi_master.sv
hdl/hsi_slave.sv
hdl/umio_hsi_top.sv
verification/umio_hsi_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= umio_hsi_tb
RTL_TOP   ?= umio_hsi_top
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

SOURCES := $(wildcard hdl/*.sv include/*.svh verification/*.sv)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/umio_hsi_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "hsi_consts.svh"

module umio_hsi_tb
	import hsi_pkg::*;
;

	localparam int RESET_CYCLES = 5;
	localparam int TAB_LEN      = 12;
	localparam int WORD_CYCLES  = 18 * `HSI_BIT_DIV;
	// Worst case per entry is a full FRAME reply plus the command and some slack
	localparam int ENTRY_CYCLES = 40 + `HSI_FRAME_LEN * WORD_CYCLES + 20;
	localparam int LIMIT        = TAB_LEN * ENTRY_CYCLES + RESET_CYCLES;
	// Line time of one command word and a little margin
	localparam int RDY_MAX      = 10 * `HSI_BIT_DIV + 2;

	logic      clk;
	logic      rst;
	hsi_ccw_t  ccw;
	logic      ccw_tx_en;
	logic      ccw_tx_rdy;
	hsi_data_t rd_data;
	logic      rd_valid;

	// Stimulus table
	hsi_ccw_t tab_ccw [TAB_LEN];
	int       tab_n [TAB_LEN];
	bit       tab_dbl [TAB_LEN];
	hsi_ccw_t tab_ccw2 [TAB_LEN];
	int       tab_fill;

	hsi_data_t rx_q [$];
	integer    seed;
	int        mismatch_cnt;
	int        fail_cnt;
	int        cycle_cnt;

	umio_hsi_top umio_hsi_top_i (
		.clk       (clk),
		.rst       (rst),
		.ccw       (ccw),
		.ccw_tx_en (ccw_tx_en),
		.ccw_tx_rdy(ccw_tx_rdy),
		.rd_data   (rd_data),
		.rd_valid  (rd_valid)
	);

	always #5 clk = ~clk;

	// Collect reply words on the falling edge
	always @(negedge clk) begin
		if (!rst && rd_valid) begin
			rx_q.push_back(rd_data);
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= LIMIT) begin
			$display("Timeout after %0d cycles while waiting for the DUT", cycle_cnt);
			$display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
			$display("Test failed");
			$finish;
		end
	end

	function automatic hsi_ccw_t make_ccw(input hsi_op_t op, input logic [5:0] arg);
		hsi_ccw_t c;
		c.op  = op;
		c.arg = arg;
		return c;
	endfunction

	// Expected reply word k for a command
	function automatic hsi_data_t expect_word(input hsi_ccw_t c, input int k);
		logic [7:0] a;
		a = {2'b00, c.arg};
		case (c.op)
			OP_READ_ID: return `HSI_DEV_ID;
			OP_ECHO:    return {a, ~a};
			OP_FRAME:   return {a, k[7:0]};
			default:    return 16'h0000;
		endcase
	endfunction

	function automatic logic [5:0] rand_arg();
		logic [31:0] r;
		r = $random(seed);
		return r[5:0];
	endfunction

	task automatic add_entry(input hsi_ccw_t c, input int n, input bit dbl, input hsi_ccw_t c2);
		tab_ccw[tab_fill]  = c;
		tab_n[tab_fill]    = n;
		tab_dbl[tab_fill]  = dbl;
		tab_ccw2[tab_fill] = c2;
		tab_fill           = tab_fill + 1;
	endtask

	task automatic check_data(input string name, input hsi_data_t got, input hsi_data_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			mismatch_cnt = mismatch_cnt + 1;
		end
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
			mismatch_cnt = mismatch_cnt + 1;
		end
	endtask

	// Starts and ends 1 ns after a rising edge
	task automatic send_ccw(input hsi_ccw_t c);
		while (!ccw_tx_rdy) begin
			@(posedge clk);
			#1;
		end
		ccw       = c;
		ccw_tx_en = 1'b1;
		@(posedge clk);
		#1;
		ccw_tx_en = 1'b0;
		check_level("ccw_tx_rdy", ccw_tx_rdy, 1'b0);
	endtask

	// Strobe that the busy master has to drop
	task automatic pulse_while_busy(input hsi_ccw_t c);
		ccw       = c;
		ccw_tx_en = 1'b1;
		@(posedge clk);
		#1;
		ccw_tx_en = 1'b0;
		check_level("ccw_tx_rdy", ccw_tx_rdy, 1'b0);
	endtask

	// A held second command would keep the master busy for another word
	task automatic wait_ready(input int max_cycles);
		int n;
		n = 0;
		while (!ccw_tx_rdy && n <= max_cycles) begin
			@(posedge clk);
			#1;
			n = n + 1;
		end
		if (!ccw_tx_rdy) begin
			$display("ccw_tx_rdy stayed low for more than %0d cycles after a command",
				max_cycles);
			fail_cnt = fail_cnt + 1;
		end
	endtask

	initial begin
		hsi_data_t got;
		clk          = 1'b0;
		rst          = 1'b1;
		ccw          = '0;
		ccw_tx_en    = 1'b0;
		seed         = 32'h4783_f1f2;
		mismatch_cnt = 0;
		fail_cnt     = 0;
		cycle_cnt    = 0;
		tab_fill     = 0;

		add_entry(make_ccw(OP_READ_ID, 6'h00), 1, 1'b0, '0);
		add_entry(make_ccw(OP_ECHO, rand_arg()), 1, 1'b0, '0);
		add_entry(make_ccw(OP_ECHO, rand_arg()), 1, 1'b0, '0);
		add_entry(make_ccw(OP_ECHO, rand_arg()), 1, 1'b0, '0);
		add_entry(make_ccw(OP_FRAME, rand_arg()), `HSI_FRAME_LEN, 1'b0, '0);
		// NOP with an ECHO right behind it
		add_entry(make_ccw(OP_NOP, rand_arg()), 0, 1'b0, '0);
		add_entry(make_ccw(OP_ECHO, rand_arg()), 1, 1'b0, '0);
		add_entry(make_ccw(OP_FRAME, rand_arg()), `HSI_FRAME_LEN, 1'b0, '0);
		add_entry(make_ccw(OP_READ_ID, 6'h15), 1, 1'b1, make_ccw(OP_FRAME, 6'h2a));
		add_entry(make_ccw(OP_ECHO, rand_arg()), 1, 1'b1, make_ccw(OP_ECHO, rand_arg()));
		add_entry(make_ccw(OP_FRAME, 6'h3f), `HSI_FRAME_LEN, 1'b0, '0);
		add_entry(make_ccw(OP_ECHO, 6'h3f), 1, 1'b0, '0);

		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst = 1'b0;

		// Quiet link after reset
		repeat (10) begin
			@(posedge clk);
			#1;
			check_level("ccw_tx_rdy", ccw_tx_rdy, 1'b1);
		end
		if (rx_q.size() != 0) begin
			$display("rd_valid pulsed %0d times before the first command", rx_q.size());
			fail_cnt = fail_cnt + 1;
			rx_q.delete();
		end

		for (int i = 0; i < TAB_LEN; i++) begin
			if (rx_q.size() != 0) begin
				$display("%0d extra reply words arrived before entry %0d", rx_q.size(), i);
				fail_cnt = fail_cnt + 1;
				rx_q.delete();
			end
			send_ccw(tab_ccw[i]);
			if (tab_dbl[i]) begin
				pulse_while_busy(tab_ccw2[i]);
				wait_ready(RDY_MAX);
			end
			while (rx_q.size() < tab_n[i]) begin
				@(posedge clk);
				#1;
			end
			for (int k = 0; k < tab_n[i]; k++) begin
				got = rx_q.pop_front();
				check_data($sformatf("rd_data entry %0d word %0d", i, k), got,
					expect_word(tab_ccw[i], k));
			end
		end

		// Long enough for any stray reply to show up
		repeat (2 * WORD_CYCLES + 20) @(posedge clk);
		#1;
		check_level("ccw_tx_rdy", ccw_tx_rdy, 1'b1);
		if (rx_q.size() != 0) begin
			$display("%0d extra reply words arrived after the last entry", rx_q.size());
			fail_cnt = fail_cnt + 1;
		end

		$display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
		if (mismatch_cnt == 0 && fail_cnt == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: hdl/umio_hsi_top.sv
`timescale 1ns/1ps
`default_nettype none

module umio_hsi_top
	import hsi_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  hsi_ccw_t  ccw,
	input  logic      ccw_tx_en,
	output logic      ccw_tx_rdy,
	output hsi_data_t rd_data,
	output logic      rd_valid
);

	// Serial lines between the two ends
	logic com;
	logic dat;

	hsi_master hsi_mstr (
		.clk       (clk),
		.rst       (rst),
		.ccw_tx_en (ccw_tx_en),
		.ccw       (ccw),
		.ccw_tx_rdy(ccw_tx_rdy),
		.com       (com),
		.dat       (dat),
		.rd_data   (rd_data),
		.rd_valid  (rd_valid)
	);

	hsi_slave hsi_slv (
		.clk(clk),
		.rst(rst),
		.com(com),
		.dat(dat)
	);

endmodule

`default_nettype wire

// File: hdl/hsi_slave.sv
`timescale 1ns/1ps
`default_nettype none

`include "hsi_consts.svh"

module hsi_slave
	import hsi_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic com,
	output logic dat
);

	localparam int IW = $clog2(`HSI_FRAME_LEN);

	localparam logic [IW-1:0] LAST_IDX = IW'(`HSI_FRAME_LEN - 1);

	typedef enum logic {
		ST_IDLE,
		ST_REPLY
	} state_t;

	state_t        state;
	hsi_ccw_t      cmd;
	logic          cmd_done;
	hsi_op_t       op_q;
	logic [5:0]    arg_q;
	logic [IW-1:0] word_idx;
	logic [7:0]    arg_byte;
	hsi_data_t     reply_word;
	logic          tx_idle;
	logic          tx_send;
	logic          last_word;
	logic          cmd_take;

	hsi_deserializer #(
		.payload_t(hsi_ccw_t)
	) com_des (
		.clk    (clk),
		.rst    (rst),
		.line   (com),
		.payload(cmd),
		.done   (cmd_done)
	);

	// New commands only once the previous reply has fully left the line
	assign cmd_take  = (state == ST_IDLE) && cmd_done && tx_idle;
	assign tx_send   = (state == ST_REPLY) && tx_idle;
	assign last_word = (op_q != OP_FRAME) || (word_idx == LAST_IDX);
	assign arg_byte  = {2'b00, arg_q};

	always_comb begin
		case (op_q)
			OP_READ_ID: reply_word = `HSI_DEV_ID;
			OP_ECHO:    reply_word = {arg_byte, ~arg_byte};
			OP_FRAME:   reply_word = {arg_byte, 8'(word_idx)};
			default:    reply_word = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= ST_IDLE;
			op_q     <= OP_NOP;
			word_idx <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					// NOP never leaves idle
					if (cmd_take && cmd.op != OP_NOP) begin
						state    <= ST_REPLY;
						op_q     <= cmd.op;
						word_idx <= '0;
					end
				end
				ST_REPLY: begin
					if (tx_send) begin
						if (last_word) begin
							state <= ST_IDLE;
						end else begin
							word_idx <= word_idx + 1'b1;
						end
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_take) begin
			arg_q <= cmd.arg;
		end
	end

	hsi_serializer #(
		.payload_t(hsi_data_t)
	) dat_ser (
		.clk    (clk),
		.rst    (rst),
		.send   (tx_send),
		.payload(reply_word),
		.idle   (tx_idle),
		.line   (dat)
	);

endmodule

`default_nettype wire

// File: hdl/hsi_master.sv
`timescale 1ns/1ps
`default_nettype none

module hsi_master
	import hsi_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      ccw_tx_en,
	input  hsi_ccw_t  ccw,
	output logic      ccw_tx_rdy,
	output logic      com,
	input  logic      dat,
	output hsi_data_t rd_data,
	output logic      rd_valid
);

	hsi_ccw_t ccw_q;
	logic     pending;
	logic     tx_idle;
	logic     tx_send;
	logic     accept;

	// Busy as soon as a command is held, before the serializer starts
	assign ccw_tx_rdy = tx_idle && !pending;
	assign accept     = ccw_tx_en && ccw_tx_rdy;
	assign tx_send    = pending && tx_idle;

	always_ff @(posedge clk) begin
		if (rst) begin
			pending <= 1'b0;
		end else if (accept) begin
			pending <= 1'b1;
		end else if (tx_send) begin
			pending <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			ccw_q <= ccw;
		end
	end

	hsi_serializer #(
		.payload_t(hsi_ccw_t)
	) ccw_ser (
		.clk    (clk),
		.rst    (rst),
		.send   (tx_send),
		.payload(ccw_q),
		.idle   (tx_idle),
		.line   (com)
	);

	// Reply words go straight out
	hsi_deserializer #(
		.payload_t(hsi_data_t)
	) dat_des (
		.clk    (clk),
		.rst    (rst),
		.line   (dat),
		.payload(rd_data),
		.done   (rd_valid)
	);

endmodule

`default_nettype wire

// File: hdl/hsi_deserializer.sv
`timescale 1ns/1ps
`default_nettype none

`include "hsi_consts.svh"

module hsi_deserializer #(
	parameter type payload_t = logic [7:0]
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     line,
	output payload_t payload,
	output logic     done
);

	localparam int W   = $bits(payload_t);
	localparam int DIV = `HSI_BIT_DIV;
	localparam int DW  = $clog2(DIV + 1);
	localparam int BW  = $clog2(W + 2);

	localparam logic [DW-1:0] DIV_LAST = DW'(DIV - 1);
	localparam logic [DW-1:0] DIV_MID  = DW'(DIV / 2);
	localparam logic [BW-1:0] STOP_IDX = BW'(W + 1);

	logic [1:0]    sync;
	logic          line_prev;
	logic          busy;
	logic [DW-1:0] div_cnt;
	logic [BW-1:0] bit_cnt;
	logic [W-1:0]  shreg;
	logic          start_edge;
	logic          sample;

	// Falling edge of the synchronized line while waiting
	assign start_edge = !busy && line_prev && !sync[1];
	assign sample     = busy && (div_cnt == DIV_MID);

	// Register holds still from the last data bit until the next word
	assign payload = payload_t'(shreg);

	always_ff @(posedge clk) begin
		if (rst) begin
			sync      <= 2'b11;
			line_prev <= 1'b1;
		end else begin
			sync      <= {sync[0], line};
			line_prev <= sync[1];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			busy    <= 1'b0;
			done    <= 1'b0;
			div_cnt <= '0;
			bit_cnt <= '0;
		end else begin
			done <= 1'b0;
			if (start_edge) begin
				// Edge cycle counts as offset 0 of the start bit
				busy    <= 1'b1;
				div_cnt <= DW'(1);
				bit_cnt <= '0;
			end else if (busy) begin
				div_cnt <= (div_cnt == DIV_LAST) ? '0 : div_cnt + 1'b1;
				if (sample) begin
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == '0 && sync[1]) begin
						// Start bit gone high at mid-bit, treat as a glitch
						busy <= 1'b0;
					end else if (bit_cnt == STOP_IDX) begin
						busy <= 1'b0;
						done <= 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (sample && bit_cnt != '0 && bit_cnt != STOP_IDX) begin
			shreg <= {shreg[W-2:0], sync[1]};
		end
	end

endmodule

`default_nettype wire

// File: hdl/hsi_serializer.sv
`timescale 1ns/1ps
`default_nettype none

`include "hsi_consts.svh"

module hsi_serializer #(
	parameter type payload_t = logic [7:0]
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     send,
	input  payload_t payload,
	output logic     idle,
	output logic     line
);

	localparam int W   = $bits(payload_t);
	localparam int DIV = `HSI_BIT_DIV;
	localparam int DW  = $clog2(DIV + 1);
	localparam int BW  = $clog2(W + 2);

	localparam logic [DW-1:0] DIV_LAST = DW'(DIV - 1);
	localparam logic [BW-1:0] STOP_IDX = BW'(W + 1);

	logic          busy;
	logic [DW-1:0] div_cnt;
	// Index of the bit now on the line, start bit is 0
	logic [BW-1:0] bit_cnt;
	// Payload MSB first, stop bit in the LSB
	logic [W:0]    shreg;

	assign idle = ~busy;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy    <= 1'b0;
			line    <= 1'b1;
			div_cnt <= '0;
			bit_cnt <= '0;
		end else if (!busy) begin
			if (send) begin
				// Start bit goes out on the next cycle
				busy    <= 1'b1;
				line    <= 1'b0;
				div_cnt <= '0;
				bit_cnt <= '0;
			end
		end else if (div_cnt == DIV_LAST) begin
			div_cnt <= '0;
			if (bit_cnt == STOP_IDX) begin
				// Stop bit done, back to idle high
				busy <= 1'b0;
				line <= 1'b1;
			end else begin
				line    <= shreg[W];
				bit_cnt <= bit_cnt + 1'b1;
			end
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!busy && send) begin
			shreg <= {payload, 1'b1};
		end else if (busy && div_cnt == DIV_LAST) begin
			shreg <= {shreg[W-1:0], 1'b0};
		end
	end

endmodule

`default_nettype wire

// File: hdl/hsi_pkg.sv
`default_nettype none

package hsi_pkg;

	// Command opcodes, upper two bits of a command word
	typedef enum logic [1:0] {
		OP_READ_ID = 2'd0,
		OP_ECHO    = 2'd1,
		OP_FRAME   = 2'd2,
		OP_NOP     = 2'd3
	} hsi_op_t;

	// Command word sent on com
	typedef struct packed {
		hsi_op_t    op;
		logic [5:0] arg;
	} hsi_ccw_t;

	// Data word returned on dat
	typedef logic [15:0] hsi_data_t;

endpackage

`default_nettype wire

// File: include/hsi_consts.svh
`ifndef HSI_CONSTS_SVH
`define HSI_CONSTS_SVH

// Clocks per serial bit on the com and dat lines
`define HSI_BIT_DIV 4

// Words returned for a FRAME command
`define HSI_FRAME_LEN 4

// Identifier answered to READ_ID
`define HSI_DEV_ID 16'hA55A

`endif
